// ==== all.f ====
hdl/vfu_pkg.sv
hdl/vfu_req_buffer.sv
hdl/vfu_sequencer.sv
hdl/vfu_int_lane.sv
hdl/vfu_top.sv
testbench/vfu_properties.sv
testbench/tb_vfu.sv

// ==== hdl/vfu_int_lane.sv ====
/* One 32-bit integer SIMD lane. Splits both operands into bytes, halves or
   a single word by the element width, applies the operation per element
   with no carry across element borders, and registers the result. */

`timescale 1ns/1ps
`default_nettype none

module vfu_int_lane (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     valid_i,
  input  vfu_pkg::vfu_op_e         op_i,
  input  vfu_pkg::vew_e            sew_i,
  input  logic [vfu_pkg::ELEN-1:0] op_a_i,
  input  logic [vfu_pkg::ELEN-1:0] op_b_i,
  output logic [vfu_pkg::ELEN-1:0] result_o,
  output logic                     result_valid_o
);

  // Operands arrive zero-extended, so unsigned compares hold at every width
  function automatic logic [31:0] alu_op(input vfu_pkg::vfu_op_e op,
                                         input logic [31:0] a,
                                         input logic [31:0] b);
    case (op)
      vfu_pkg::VADD:  return a + b;
      vfu_pkg::VSUB:  return a - b;
      vfu_pkg::VAND:  return a & b;
      vfu_pkg::VOR:   return a | b;
      vfu_pkg::VXOR:  return a ^ b;
      vfu_pkg::VMINU: return (a < b) ? a : b;
      vfu_pkg::VMAXU: return (a < b) ? b : a;
      default:        return '0;
    endcase
  endfunction

  vfu_pkg::lane_word_u res;
  logic [vfu_pkg::ELEN-1:0] result_q;
  logic                     valid_q;

  always_comb begin
    vfu_pkg::lane_word_u va;
    vfu_pkg::lane_word_u vb;
    va  = op_a_i;
    vb  = op_b_i;
    res = '0;
    case (sew_i)
      vfu_pkg::EW_8: begin
        for (int i = 0; i < vfu_pkg::ELENB; i++) begin
          res.b[i] = 8'(alu_op(op_i, 32'(va.b[i]), 32'(vb.b[i])));
        end
      end
      vfu_pkg::EW_16: begin
        for (int i = 0; i < vfu_pkg::ELENB / 2; i++) begin
          res.h[i] = 16'(alu_op(op_i, 32'(va.h[i]), 32'(vb.h[i])));
        end
      end
      default: res.w = alu_op(op_i, va.w, vb.w);
    endcase
  end

  // Result register
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      result_q <= res.w;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  assign result_o       = result_q;
  assign result_valid_o = valid_q;

endmodule

`default_nettype wire

// ==== hdl/vfu_pkg.sv ====
/* Shared definitions for the integer vector functional unit: element width
   and operation encodings, the lane word view and the VRF geometry.
   RTL and testbench refer to these by scoped name. */

`default_nettype none

package vfu_pkg;

  // Lane word geometry
  localparam int unsigned ELEN  = 32;
  localparam int unsigned ELENB = ELEN / 8;

  // VRF geometry
  localparam int unsigned NR_VREGS = 32;
  localparam int unsigned VREG_W   = $clog2(NR_VREGS);

  // Scalar register index and instruction ID widths
  localparam int unsigned GPR_W = 5;
  localparam int unsigned ID_W  = 3;

  // Element width, also log2 of the bytes per element
  typedef enum logic [1:0] {
    EW_8  = 2'd0,
    EW_16 = 2'd1,
    EW_32 = 2'd2
  } vew_e;

  // Integer operations, min and max are unsigned
  typedef enum logic [2:0] {
    VADD  = 3'd0,
    VSUB  = 3'd1,
    VAND  = 3'd2,
    VOR   = 3'd3,
    VXOR  = 3'd4,
    VMINU = 3'd5,
    VMAXU = 3'd6
  } vfu_op_e;

  // One lane word seen as bytes, halves or a full word
  typedef union packed {
    logic [ELENB-1:0][7:0]    b;
    logic [ELENB/2-1:0][15:0] h;
    logic [ELEN-1:0]          w;
  } lane_word_u;

endpackage

`default_nettype wire

// ==== hdl/vfu_req_buffer.sv ====
/* Two-entry request FIFO in front of the sequencer. The next instruction
   waits here while the current one runs; the head is popped on completion. */

`timescale 1ns/1ps
`default_nettype none

module vfu_req_buffer #(
  parameter int unsigned WIDTH = 8
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic [WIDTH-1:0] data_i,
  input  logic             valid_i,
  output logic             ready_o,
  output logic [WIDTH-1:0] data_o,
  output logic             valid_o,
  input  logic             pop_i
);

  logic [WIDTH-1:0] mem_q [2];
  logic             wr_ptr_q;
  logic             rd_ptr_q;
  logic [1:0]       count_q;
  logic             push;
  logic             pop;

  assign ready_o = (count_q != 2'd2);
  assign valid_o = (count_q != 2'd0);
  assign push    = valid_i && ready_o;
  assign pop     = pop_i && valid_o;
  assign data_o  = mem_q[rd_ptr_q];

  // Pointers and fill level
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      count_q <= count_q + 2'(push) - 2'(pop);
    end
  end

  // Entry storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/vfu_sequencer.sv ====
/* Word sequencer of the vector functional unit. Walks the head instruction
   through the VRF one word per issue and tags each issue so the result
   cycle can form the write, its byte enables and the response. */

`timescale 1ns/1ps
`default_nettype none

module vfu_sequencer #(
  parameter  int unsigned N_LANES           = 2,
  parameter  int unsigned NR_WORDS_PER_VREG = 4,
  localparam int unsigned VL_W   = $clog2(NR_WORDS_PER_VREG * N_LANES * vfu_pkg::ELENB + 1),
  localparam int unsigned ADDR_W = $clog2(vfu_pkg::NR_VREGS * NR_WORDS_PER_VREG),
  localparam int unsigned WBE_W  = N_LANES * vfu_pkg::ELENB
) (
  input  logic                          clk_i,
  input  logic                          rst_i,
  // Head of the request buffer
  input  logic                          head_valid_i,
  input  vfu_pkg::vew_e                 vsew_i,
  input  logic [VL_W-1:0]               vl_i,
  input  logic [vfu_pkg::VREG_W-1:0]    vs1_i,
  input  logic [vfu_pkg::VREG_W-1:0]    vs2_i,
  input  logic [vfu_pkg::VREG_W-1:0]    vd_i,
  input  logic                          use_vs1_i,
  input  logic                          is_scalar_i,
  input  logic [vfu_pkg::ID_W-1:0]      id_i,
  input  logic [vfu_pkg::GPR_W-1:0]     rd_i,
  // Handshakes
  input  logic [1:0]                    vrf_rvalid_i,
  input  logic                          rsp_ready_i,
  input  logic                          result_valid_i,
  output logic                          pop_o,
  output logic                          issue_o,
  // VRF control
  output logic [1:0][ADDR_W-1:0]        vrf_raddr_o,
  output logic [1:0]                    vrf_re_o,
  output logic [ADDR_W-1:0]             vrf_waddr_o,
  output logic                          vrf_we_o,
  output logic [WBE_W-1:0]              vrf_wbe_o,
  // Response
  output logic                          rsp_valid_o,
  output logic [vfu_pkg::ID_W-1:0]      rsp_id_o,
  output logic [vfu_pkg::GPR_W-1:0]     rsp_rd_o,
  output logic                          rsp_wb_o
);

  localparam int unsigned NB_W = VL_W + 2;
  localparam logic [VL_W:0] EPW_MAX = (VL_W + 1)'(N_LANES * vfu_pkg::ELENB);

  //////////////////////////////////////////////////////////////////////
  // Issue control

  logic [VL_W-1:0]          elems_q;
  logic [VL_W:0]            epw;
  logic [VL_W:0]            elems_next;
  logic                     start;
  logic                     last;
  logic                     operands_ok;
  // Index 0 is vs2, 1 is vs1, 2 is vd
  logic [2:0][ADDR_W-1:0]   base_addr;
  logic [2:0][ADDR_W-1:0]   cur_addr;
  logic [2:0][ADDR_W-1:0]   addr_q;

  // Elements per VRF word shrink with wider elements
  assign epw        = EPW_MAX >> vsew_i;
  assign elems_next = {1'b0, elems_q} + epw;
  assign last       = is_scalar_i || (elems_next >= {1'b0, vl_i});
  assign start      = (elems_q == '0);

  assign base_addr[0] = ADDR_W'(vs2_i) * ADDR_W'(NR_WORDS_PER_VREG);
  assign base_addr[1] = ADDR_W'(vs1_i) * ADDR_W'(NR_WORDS_PER_VREG);
  assign base_addr[2] = ADDR_W'(vd_i) * ADDR_W'(NR_WORDS_PER_VREG);
  // First word addresses come straight from the head
  assign cur_addr     = start ? base_addr : addr_q;

  // Scalar work reads nothing but needs room for its response
  assign operands_ok = is_scalar_i ? rsp_ready_i
                                   : (vrf_rvalid_i[0] && (!use_vs1_i || vrf_rvalid_i[1]));
  assign issue_o     = head_valid_i && operands_ok;
  assign pop_o       = issue_o && last;

  assign vrf_re_o[0]    = head_valid_i && !is_scalar_i;
  assign vrf_re_o[1]    = head_valid_i && !is_scalar_i && use_vs1_i;
  assign vrf_raddr_o[0] = cur_addr[0];
  assign vrf_raddr_o[1] = cur_addr[1];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      elems_q <= '0;
      addr_q  <= '0;
    end else if (issue_o) begin
      elems_q <= last ? '0 : elems_next[VL_W-1:0];
      for (int k = 0; k < 3; k++) begin
        addr_q[k] <= cur_addr[k] + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Write tag, follows the issue by one cycle like the lane results

  logic [ADDR_W-1:0]        tag_addr_q;
  logic                     tag_last_q;
  logic                     tag_scalar_q;
  logic [VL_W-1:0]          tag_rem_q;
  vfu_pkg::vew_e            tag_vsew_q;
  logic [vfu_pkg::ID_W-1:0] tag_id_q;
  logic [vfu_pkg::GPR_W-1:0] tag_rd_q;
  logic [NB_W-1:0]          tail_bytes;

  always_ff @(posedge clk_i) begin
    if (issue_o) begin
      tag_addr_q   <= cur_addr[2];
      tag_last_q   <= last;
      tag_scalar_q <= is_scalar_i;
      tag_rem_q    <= vl_i - elems_q;
      tag_vsew_q   <= vsew_i;
      tag_id_q     <= id_i;
      tag_rd_q     <= rd_i;
    end
  end

  // Bytes still owed on the last word
  assign tail_bytes = NB_W'(tag_rem_q) << tag_vsew_q;

  assign vrf_waddr_o = tag_addr_q;
  assign vrf_we_o    = result_valid_i && !tag_scalar_q;
  assign vrf_wbe_o   = tag_last_q ? ~({WBE_W{1'b1}} << tail_bytes) : {WBE_W{1'b1}};

  assign rsp_valid_o = result_valid_i && tag_last_q;
  assign rsp_id_o    = tag_id_q;
  assign rsp_rd_o    = tag_rd_q;
  assign rsp_wb_o    = tag_scalar_q;

endmodule

`default_nettype wire

// ==== hdl/vfu_top.sv ====
/* Top of the integer vector functional unit. Buffers requests, sequences
   them word by word over the VRF ports and runs each word through N_LANES
   integer lanes. Scalar work runs on lane 0 and returns on the response. */

`timescale 1ns/1ps
`default_nettype none

module vfu_top #(
  parameter  int unsigned N_LANES           = 2,
  parameter  int unsigned NR_WORDS_PER_VREG = 4,
  localparam int unsigned VL_W   = $clog2(NR_WORDS_PER_VREG * N_LANES * vfu_pkg::ELENB + 1),
  localparam int unsigned ADDR_W = $clog2(vfu_pkg::NR_VREGS * NR_WORDS_PER_VREG),
  localparam int unsigned WORD_W = N_LANES * vfu_pkg::ELEN,
  localparam int unsigned WBE_W  = N_LANES * vfu_pkg::ELENB
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  // Request
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  input  vfu_pkg::vfu_op_e           req_op_i,
  input  vfu_pkg::vew_e              req_vsew_i,
  input  logic [VL_W-1:0]            req_vl_i,
  input  logic [vfu_pkg::VREG_W-1:0] req_vs1_i,
  input  logic [vfu_pkg::VREG_W-1:0] req_vs2_i,
  input  logic [vfu_pkg::VREG_W-1:0] req_vd_i,
  input  logic [vfu_pkg::ELEN-1:0]   req_rs1_i,
  input  logic [vfu_pkg::ELEN-1:0]   req_rs2_i,
  input  logic                       req_use_vs1_i,
  input  logic                       req_is_scalar_i,
  input  logic [vfu_pkg::ID_W-1:0]   req_id_i,
  input  logic [vfu_pkg::GPR_W-1:0]  req_rd_i,
  // Response
  output logic                       rsp_valid_o,
  input  logic                       rsp_ready_i,
  output logic [vfu_pkg::ID_W-1:0]   rsp_id_o,
  output logic [vfu_pkg::GPR_W-1:0]  rsp_rd_o,
  output logic                       rsp_wb_o,
  output logic [vfu_pkg::ELEN-1:0]   rsp_result_o,
  // VRF, read port 0 is vs2 and port 1 is vs1
  output logic [1:0][ADDR_W-1:0]     vrf_raddr_o,
  output logic [1:0]                 vrf_re_o,
  input  logic [1:0][WORD_W-1:0]     vrf_rdata_i,
  input  logic [1:0]                 vrf_rvalid_i,
  output logic [ADDR_W-1:0]          vrf_waddr_o,
  output logic [WORD_W-1:0]          vrf_wdata_o,
  output logic                       vrf_we_o,
  output logic [WBE_W-1:0]           vrf_wbe_o
);

  localparam int unsigned ELEN  = vfu_pkg::ELEN;
  localparam int unsigned REQ_W = $bits(vfu_pkg::vfu_op_e) + $bits(vfu_pkg::vew_e) + VL_W
                                + 3 * vfu_pkg::VREG_W + 2 * ELEN + 2
                                + vfu_pkg::ID_W + vfu_pkg::GPR_W;

  //////////////////////////////////////////////////////////////////////
  // Request buffer

  logic [REQ_W-1:0]           req_data;
  logic [REQ_W-1:0]           head_data;
  logic                       head_valid;
  logic                       pop;
  logic                       issue;
  logic                       lane0_valid;
  logic [2:0]                 h_op_bits;
  logic [1:0]                 h_vsew_bits;
  vfu_pkg::vfu_op_e           h_op;
  vfu_pkg::vew_e              h_vsew;
  logic [VL_W-1:0]            h_vl;
  logic [vfu_pkg::VREG_W-1:0] h_vs1;
  logic [vfu_pkg::VREG_W-1:0] h_vs2;
  logic [vfu_pkg::VREG_W-1:0] h_vd;
  logic [ELEN-1:0]            h_rs1;
  logic [ELEN-1:0]            h_rs2;
  logic                       h_use_vs1;
  logic                       h_is_scalar;
  logic [vfu_pkg::ID_W-1:0]   h_id;
  logic [vfu_pkg::GPR_W-1:0]  h_rd;

  assign req_data = {req_op_i, req_vsew_i, req_vl_i, req_vs1_i, req_vs2_i, req_vd_i,
                     req_rs1_i, req_rs2_i, req_use_vs1_i, req_is_scalar_i, req_id_i, req_rd_i};

  vfu_req_buffer #(
    .WIDTH (REQ_W)
  ) i_req_buffer (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .data_i  (req_data),
    .valid_i (req_valid_i),
    .ready_o (req_ready_o),
    .data_o  (head_data),
    .valid_o (head_valid),
    .pop_i   (pop)
  );

  assign {h_op_bits, h_vsew_bits, h_vl, h_vs1, h_vs2, h_vd,
          h_rs1, h_rs2, h_use_vs1, h_is_scalar, h_id, h_rd} = head_data;
  assign h_op   = vfu_pkg::vfu_op_e'(h_op_bits);
  assign h_vsew = vfu_pkg::vew_e'(h_vsew_bits);

  //////////////////////////////////////////////////////////////////////
  // Sequencer

  vfu_sequencer #(
    .N_LANES           (N_LANES),
    .NR_WORDS_PER_VREG (NR_WORDS_PER_VREG)
  ) i_sequencer (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .head_valid_i   (head_valid),
    .vsew_i         (h_vsew),
    .vl_i           (h_vl),
    .vs1_i          (h_vs1),
    .vs2_i          (h_vs2),
    .vd_i           (h_vd),
    .use_vs1_i      (h_use_vs1),
    .is_scalar_i    (h_is_scalar),
    .id_i           (h_id),
    .rd_i           (h_rd),
    .vrf_rvalid_i   (vrf_rvalid_i),
    .rsp_ready_i    (rsp_ready_i),
    .result_valid_i (lane0_valid),
    .pop_o          (pop),
    .issue_o        (issue),
    .vrf_raddr_o    (vrf_raddr_o),
    .vrf_re_o       (vrf_re_o),
    .vrf_waddr_o    (vrf_waddr_o),
    .vrf_we_o       (vrf_we_o),
    .vrf_wbe_o      (vrf_wbe_o),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_id_o       (rsp_id_o),
    .rsp_rd_o       (rsp_rd_o),
    .rsp_wb_o       (rsp_wb_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Operands and lanes

  vfu_pkg::lane_word_u rs1_rep;
  logic [WORD_W-1:0]   op1_word;
  logic [WORD_W-1:0]   lane_result;
  logic [N_LANES-1:0]  lane_valid;

  // Scalar operand copied into every element of a lane word
  always_comb begin
    rs1_rep.w = h_rs1;
    case (h_vsew)
      vfu_pkg::EW_8: begin
        for (int i = 0; i < vfu_pkg::ELENB; i++) begin
          rs1_rep.b[i] = h_rs1[7:0];
        end
      end
      vfu_pkg::EW_16: begin
        for (int i = 0; i < vfu_pkg::ELENB / 2; i++) begin
          rs1_rep.h[i] = h_rs1[15:0];
        end
      end
      default: ;
    endcase
  end

  assign op1_word = h_use_vs1 ? vrf_rdata_i[1] : {N_LANES{rs1_rep.w}};

  for (genvar l = 0; l < N_LANES; l++) begin : gen_lanes
    logic [ELEN-1:0] op_a;
    logic [ELEN-1:0] op_b;

    assign op_a = h_is_scalar ? h_rs2 : vrf_rdata_i[0][l*ELEN +: ELEN];
    assign op_b = h_is_scalar ? h_rs1 : op1_word[l*ELEN +: ELEN];

    // Only lane 0 takes scalar work
    vfu_int_lane i_lane (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .valid_i        (issue && (!h_is_scalar || l == 0)),
      .op_i           (h_op),
      .sew_i          (h_vsew),
      .op_a_i         (op_a),
      .op_b_i         (op_b),
      .result_o       (lane_result[l*ELEN +: ELEN]),
      .result_valid_o (lane_valid[l])
    );

    // Idle lanes put zero on the write bus
    assign vrf_wdata_o[l*ELEN +: ELEN] = lane_valid[l] ? lane_result[l*ELEN +: ELEN] : '0;
  end

  // Lanes run in lockstep, lane 0 speaks for all
  assign lane0_valid  = lane_valid[0];
  assign rsp_result_o = rsp_wb_o ? lane_result[ELEN-1:0] : '0;

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the vector unit testbench with Verilator.
# The run fails when the simulator fails or the log reports a failure.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_vfu -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_vfu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
  exit 1
fi
if ! grep -q "All tests passed" "$LOG"; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0

// ==== testbench/tb_vfu.sv ====
/* Testbench for the integer vector unit. Models the VRF with random stall
   of read data, streams instructions from the stimulus file and checks
   every write, the tail bytes and each response against a reference. */

`timescale 1ns/1ps
`default_nettype none

module tb_vfu;

  localparam int unsigned N_LANES           = 2;
  localparam int unsigned NR_WORDS_PER_VREG = 4;
  localparam int unsigned WORD_W = N_LANES * vfu_pkg::ELEN;
  localparam int unsigned WBE_W  = N_LANES * vfu_pkg::ELENB;
  localparam int unsigned DEPTH  = vfu_pkg::NR_VREGS * NR_WORDS_PER_VREG;
  localparam int unsigned ADDR_W = $clog2(DEPTH);
  localparam int unsigned VL_W   = $clog2(NR_WORDS_PER_VREG * WBE_W + 1);

  typedef struct packed {
    logic [2:0]  op;
    logic [1:0]  sew;
    logic [5:0]  vl;
    logic [4:0]  vs1;
    logic [4:0]  vs2;
    logic [4:0]  vd;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic        use_vs1;
    logic        scalar;
    logic [2:0]  id;
    logic [4:0]  rd;
    logic [31:0] expected;
  } instr_t;

  logic clk_i;
  logic rst_i;
  logic req_valid;
  logic req_ready;
  vfu_pkg::vfu_op_e req_op;
  vfu_pkg::vew_e req_vsew;
  logic [VL_W-1:0] req_vl;
  logic [4:0] req_vs1;
  logic [4:0] req_vs2;
  logic [4:0] req_vd;
  logic [31:0] req_rs1;
  logic [31:0] req_rs2;
  logic req_use_vs1;
  logic req_is_scalar;
  logic [2:0] req_id;
  logic [4:0] req_rd;
  logic rsp_valid;
  logic rsp_ready;
  logic [2:0] rsp_id;
  logic [4:0] rsp_rd;
  logic rsp_wb;
  logic [31:0] rsp_result;
  logic [1:0][ADDR_W-1:0] vrf_raddr;
  logic [1:0] vrf_re;
  logic [1:0][WORD_W-1:0] vrf_rdata;
  logic [1:0] vrf_rvalid;
  logic [ADDR_W-1:0] vrf_waddr;
  logic [WORD_W-1:0] vrf_wdata;
  logic vrf_we;
  logic [WBE_W-1:0] vrf_wbe;

  logic [WORD_W-1:0] vrf_mem [DEPTH];
  logic [WORD_W-1:0] shadow [DEPTH];
  logic [31:0] lfsr;
  instr_t prog [$];
  instr_t inflight [$];
  int errors;
  int checks;
  int rsp_count;
  int word_idx;
  int cycles;
  int limit;
  logic tail_pending;
  logic [4:0] tail_vd;
  logic ready_prev;

  vfu_top #(
    .N_LANES           (N_LANES),
    .NR_WORDS_PER_VREG (NR_WORDS_PER_VREG)
  ) i_vfu_top (
    .clk_i (clk_i), .rst_i (rst_i),
    .req_valid_i (req_valid), .req_ready_o (req_ready), .req_op_i (req_op),
    .req_vsew_i (req_vsew), .req_vl_i (req_vl), .req_vs1_i (req_vs1),
    .req_vs2_i (req_vs2), .req_vd_i (req_vd), .req_rs1_i (req_rs1),
    .req_rs2_i (req_rs2), .req_use_vs1_i (req_use_vs1),
    .req_is_scalar_i (req_is_scalar), .req_id_i (req_id), .req_rd_i (req_rd),
    .rsp_valid_o (rsp_valid), .rsp_ready_i (rsp_ready), .rsp_id_o (rsp_id),
    .rsp_rd_o (rsp_rd), .rsp_wb_o (rsp_wb), .rsp_result_o (rsp_result),
    .vrf_raddr_o (vrf_raddr), .vrf_re_o (vrf_re), .vrf_rdata_i (vrf_rdata),
    .vrf_rvalid_i (vrf_rvalid), .vrf_waddr_o (vrf_waddr), .vrf_wdata_o (vrf_wdata),
    .vrf_we_o (vrf_we), .vrf_wbe_o (vrf_wbe)
  );

  //////////////////////////////////////////////////////////////////////
  // Helpers

  // Galois LFSR stepped once per bit handed out
  function automatic logic take_bit();
    logic b;
    b    = lfsr[0];
    lfsr = b ? ((lfsr >> 1) ^ 32'ha300_0000) : (lfsr >> 1);
    return b;
  endfunction

  task automatic check_value(input string what, input logic [63:0] actual,
                             input logic [63:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %0t ns: %s got %h expected %h", $time, what, actual, expected);
    end
  endtask

  // Per element op over a VRF word
  function automatic logic [63:0] ref_word(input logic [2:0] op, input logic [1:0] sew,
                                           input logic [63:0] a, input logic [63:0] b);
    int ebits;
    logic [31:0] mask;
    logic [31:0] x;
    logic [31:0] y;
    logic [31:0] r;
    logic [63:0] res;
    ebits = 8 << sew;
    mask  = (ebits == 32) ? 32'hffff_ffff : ((32'h1 << ebits) - 1);
    res   = '0;
    for (int i = 0; i < 64 / ebits; i++) begin
      x = 32'(a >> (i * ebits)) & mask;
      y = 32'(b >> (i * ebits)) & mask;
      case (op)
        vfu_pkg::VADD:  r = x + y;
        vfu_pkg::VSUB:  r = x - y;
        vfu_pkg::VAND:  r = x & y;
        vfu_pkg::VOR:   r = x | y;
        vfu_pkg::VXOR:  r = x ^ y;
        vfu_pkg::VMINU: r = (x < y) ? x : y;
        vfu_pkg::VMAXU: r = (x > y) ? x : y;
        default:        r = '0;
      endcase
      res = res | (64'(r & mask) << (i * ebits));
    end
    return res;
  endfunction

  // Low bits of the scalar copied into every element
  function automatic logic [63:0] splat(input logic [1:0] sew, input logic [31:0] v);
    int ebits;
    logic [31:0] elem;
    logic [63:0] res;
    ebits = 8 << sew;
    elem  = (ebits == 32) ? v : (v & ((32'h1 << ebits) - 1));
    res   = '0;
    for (int i = 0; i < 64 / ebits; i++) begin
      res = res | (64'(elem) << (i * ebits));
    end
    return res;
  endfunction

  function automatic int words_of(input instr_t ins);
    int epw;
    epw = WBE_W >> ins.sew;
    return ins.scalar ? 0 : (int'(ins.vl) + epw - 1) / epw;
  endfunction

  task automatic load_program();
    int fd;
    int n;
    string line;
    logic [31:0] f [13];
    instr_t ins;
    fd = $fopen("testbench/vfu_input.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file testbench/vfu_input.txt");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                    f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11], f[12]);
        if (n != 13) begin
          $display("Stimulus line could not be parsed: %s", line);
          errors++;
        end else begin
          ins = {3'(f[0]), 2'(f[1]), 6'(f[2]), 5'(f[3]), 5'(f[4]), 5'(f[5]), f[6], f[7],
                 1'(f[8]), 1'(f[9]), 3'(f[10]), 5'(f[11]), f[12]};
          prog.push_back(ins);
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic send_instr(input instr_t ins);
    req_op        = vfu_pkg::vfu_op_e'(ins.op);
    req_vsew      = vfu_pkg::vew_e'(ins.sew);
    req_vl        = VL_W'(ins.vl);
    req_vs1       = ins.vs1;
    req_vs2       = ins.vs2;
    req_vd        = ins.vd;
    req_rs1       = ins.rs1;
    req_rs2       = ins.rs2;
    req_use_vs1   = ins.use_vs1;
    req_is_scalar = ins.scalar;
    req_id        = ins.id;
    req_rd        = ins.rd;
    req_valid     = 1'b1;
    @(negedge clk_i);
    while (!req_ready) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    inflight.push_back(ins);
    #2;
    req_valid = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // VRF model

  assign vrf_rdata[0] = vrf_mem[vrf_raddr[0]];
  assign vrf_rdata[1] = vrf_mem[vrf_raddr[1]];

  always @(posedge clk_i) begin
    if (vrf_we) begin
      for (int b = 0; b < WBE_W; b++) begin
        if (vrf_wbe[b]) begin
          vrf_mem[vrf_waddr][b*8 +: 8] <= vrf_wdata[b*8 +: 8];
        end
      end
    end
  end

  // Read data withheld about one cycle in four
  always @(posedge clk_i) begin
    #2;
    vrf_rvalid[0] = take_bit() | take_bit();
    vrf_rvalid[1] = take_bit() | take_bit();
    rsp_ready     = take_bit();
  end

  //////////////////////////////////////////////////////////////////////
  // Monitor sampled mid cycle

  task automatic record_write();
    instr_t ins;
    int epw;
    int idx;
    int bytes;
    logic [63:0] op_b;
    logic [63:0] exp;
    logic [63:0] bm;
    logic [WBE_W-1:0] wbe_exp;
    if (inflight.size() == 0 || inflight[0].scalar || word_idx >= words_of(inflight[0])) begin
      $display("Unexpected VRF write at %0t ns", $time);
      errors++;
      return;
    end
    ins   = inflight[0];
    epw   = WBE_W >> ins.sew;
    idx   = int'(ins.vd) * NR_WORDS_PER_VREG + word_idx;
    op_b  = ins.use_vs1 ? shadow[int'(ins.vs1) * NR_WORDS_PER_VREG + word_idx]
                        : splat(ins.sew, ins.rs1);
    exp   = ref_word(ins.op, ins.sew, shadow[int'(ins.vs2) * NR_WORDS_PER_VREG + word_idx],
                     op_b);
    bytes = (int'(ins.vl) - word_idx * epw) << ins.sew;
    wbe_exp = (bytes >= WBE_W) ? '1 : WBE_W'((1 << bytes) - 1);
    for (int b = 0; b < WBE_W; b++) begin
      bm[b*8 +: 8] = {8{wbe_exp[b]}};
    end
    check_value("write address", 64'(vrf_waddr), 64'(idx));
    check_value("write byte enables", 64'(vrf_wbe), 64'(wbe_exp));
    check_value("write data", vrf_wdata & bm, exp & bm);
    shadow[idx] = (shadow[idx] & ~bm) | (exp & bm);
    word_idx++;
  endtask

  task automatic record_response();
    instr_t ins;
    if (inflight.size() == 0) begin
      $display("Response at %0t ns with no instruction outstanding", $time);
      errors++;
      return;
    end
    ins = inflight.pop_front();
    check_value("response id", 64'(rsp_id), 64'(ins.id));
    check_value("response rd", 64'(rsp_rd), 64'(ins.rd));
    check_value("response wb", 64'(rsp_wb), 64'(ins.scalar));
    if (ins.scalar) begin
      check_value("scalar result", 64'(rsp_result), 64'(ins.expected));
      // Scalar issue needs room for its response
      check_value("rsp_ready_i at scalar issue", 64'(ready_prev), 64'h1);
    end else begin
      tail_pending = 1'b1;
      tail_vd      = ins.vd;
    end
    check_value("written word count", 64'(word_idx), 64'(words_of(ins)));
    word_idx = 0;
    rsp_count++;
  endtask

  // Read enables follow the instruction at the buffer head
  task automatic check_read_enables();
    logic [1:0] re_exp;
    re_exp = '0;
    if (inflight.size() > 0 && !inflight[0].scalar) begin
      re_exp = {inflight[0].use_vs1, 1'b1};
    end
    check_value("read enables", 64'(vrf_re), 64'(re_exp));
  endtask

  always @(negedge clk_i) begin
    if (!rst_i) begin
      // Whole vd compared once its last write has landed
      if (tail_pending) begin
        for (int w = 0; w < NR_WORDS_PER_VREG; w++) begin
          check_value("vd contents", vrf_mem[int'(tail_vd) * NR_WORDS_PER_VREG + w],
                      shadow[int'(tail_vd) * NR_WORDS_PER_VREG + w]);
        end
        tail_pending = 1'b0;
      end
      if (vrf_we) begin
        record_write();
      end
      if (rsp_valid) begin
        record_response();
      end
      check_read_enables();
    end
    ready_prev = rsp_ready;
  end

  //////////////////////////////////////////////////////////////////////
  // Clock, timeout and main sequence

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("Some tests failed");
      $finish;
    end
  end

  initial begin
    logic [WORD_W-1:0] word;
    rst_i = 1'b1;
    req_valid = 1'b0;
    req_op = vfu_pkg::VADD;
    req_vsew = vfu_pkg::EW_8;
    {req_vl, req_vs1, req_vs2, req_vd, req_rs1, req_rs2} = '0;
    {req_use_vs1, req_is_scalar, req_id, req_rd} = '0;
    rsp_ready = 1'b0;
    vrf_rvalid = '0;
    {errors, checks, rsp_count, word_idx, cycles, limit} = '0;
    tail_pending = 1'b0;
    tail_vd = '0;
    ready_prev = 1'b0;
    lfsr = 32'he0e0_1c18;
    for (int a = 0; a < DEPTH; a++) begin
      for (int b = 0; b < WORD_W; b++) begin
        word[b] = take_bit();
      end
      vrf_mem[a] <= word;
      shadow[a] = word;
    end
    load_program();
    limit = 200;
    foreach (prog[i]) begin
      limit += 64 * ((words_of(prog[i]) > 0) ? words_of(prog[i]) : 1);
    end
    repeat (8) @(posedge clk_i);
    #2;
    rst_i = 1'b0;
    @(negedge clk_i);
    check_value("vrf_we_o after reset", 64'(vrf_we), 64'h0);
    check_value("rsp_valid_o after reset", 64'(rsp_valid), 64'h0);
    check_value("req_ready_o after reset", 64'(req_ready), 64'h1);
    @(posedge clk_i);
    #2;
    foreach (prog[i]) begin
      send_instr(prog[i]);
    end
    while (rsp_count < prog.size()) begin
      @(posedge clk_i);
    end
    repeat (4) @(posedge clk_i);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/vfu_input.txt ====
# op sew vl vs1 vs2 vd rs1 rs2 use_vs1 scalar id rd expected, all hex
# op 0 add 1 sub 2 and 3 or 4 xor 5 minu 6 maxu, sew 0 e8 1 e16 2 e32
0 0 20 01 02 10 00000000 00000000 1 0 0 01 00000000
1 1 0b 03 04 11 00000000 00000000 1 0 1 02 00000000
2 2 05 05 06 12 00000000 00000000 1 0 2 03 00000000
3 0 0d 01 03 13 00000000 00000000 1 0 3 04 00000000
0 2 01 00 00 00 00000007 00000010 0 1 4 05 00000017
4 1 10 02 05 14 00000000 00000000 1 0 5 06 00000000
5 2 08 04 07 15 00000000 00000000 1 0 6 07 00000000
6 0 11 06 01 16 00000000 00000000 1 0 7 08 00000000
1 0 01 00 00 00 01010107 10203005 0 1 0 09 0f1f2ffe
5 0 1f 07 03 17 00000000 00000000 1 0 1 0a 00000000
6 1 07 02 06 18 00000000 00000000 1 0 2 0b 00000000
0 0 09 00 02 19 000001f3 00000000 0 0 3 0c 00000000
5 1 06 00 04 1a 12348000 00000000 0 0 4 0d 00000000
6 1 01 00 00 00 01007fff 00ff8000 0 1 5 0e 01008000
1 2 07 00 05 1b 00000005 00000000 0 0 6 0f 00000000
4 2 01 00 00 00 ffff0000 a5a5a5a5 0 1 7 10 5a5aa5a5

// ==== testbench/vfu_properties.sv ====
/* Concurrent checks on the sequencer's write, response and pop timing.
   Attached to every vfu_sequencer instance through the bind below. */

`timescale 1ns/1ps
`default_nettype none

module vfu_properties (
  input logic clk_i,
  input logic rst_i,
  input logic issue_o,
  input logic pop_o,
  input logic vrf_we_o,
  input logic rsp_valid_o
);

  // Lane results are registered, so a write trails its issue by one cycle
  a_we_after_issue: assert property (@(posedge clk_i) disable iff (rst_i)
    vrf_we_o |-> $past(issue_o))
    else $error("VRF write without an issue in the previous cycle");

  a_rsp_idle_after_reset: assert property (@(posedge clk_i)
    rst_i |=> !rsp_valid_o)
    else $error("Response valid right after a reset cycle");

  // Every buffer pop is answered by a response one cycle later
  a_rsp_after_pop: assert property (@(posedge clk_i) disable iff (rst_i)
    pop_o |=> rsp_valid_o)
    else $error("No response in the cycle after a buffer pop");

endmodule

bind vfu_sequencer vfu_properties i_vfu_properties (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .issue_o     (issue_o),
  .pop_o       (pop_o),
  .vrf_we_o    (vrf_we_o),
  .rsp_valid_o (rsp_valid_o)
);

`default_nettype wire
